//--- design/forwardPipe_config.svh
`ifndef FORWARD_PIPE_CONFIG_SVH
`define FORWARD_PIPE_CONFIG_SVH

// Operand and result width in bits
`define FP_DATA_WIDTH 16

// Number of architectural registers
`define FP_REG_COUNT 16

// Address width of the register file
// Must cover FP_REG_COUNT entries
`define FP_REG_ADDR_WIDTH 4

`endif

//--- design/forwardPipePkg.sv
`default_nettype none

`include "forwardPipe_config.svh"

package forwardPipePkg;

    // ALU operations
    // opPass hands operand B through and loads constants together with the immediate
    typedef enum logic [2:0] {
        opAdd  = 3'd0,
        opSub  = 3'd1,
        opAnd  = 3'd2,
        opOr   = 3'd3,
        opXor  = 3'd4,
        opShl  = 3'd5,
        opPass = 3'd6
    } aluOpT;

    // Register file address
    typedef logic [`FP_REG_ADDR_WIDTH-1:0] regAddrT;

    // Operand and result word
    typedef logic [`FP_DATA_WIDTH-1:0] dataT;

endpackage

`default_nettype wire

//--- design/regFile.sv
`default_nettype none

`include "forwardPipe_config.svh"

module regFile
    import forwardPipePkg::*;
(
    input  logic    clk,
    input  logic    arstN,

    // Write port, driven by the writeback register
    input  logic    wrEn,
    input  regAddrT wrAddr,
    input  dataT    wrData,

    // Two combinational read ports
    input  regAddrT rdAddrA,
    input  regAddrT rdAddrB,
    output dataT    rdDataA,
    output dataT    rdDataB
);

    dataT regs [`FP_REG_COUNT];

    // All registers read as zero until first written
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `FP_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // No write-through, a read in the write cycle returns the old value
    always_comb begin
        rdDataA = regs[rdAddrA];
        rdDataB = regs[rdAddrB];
    end

    // A write must always land on a defined register
    wrAddrKnown: assert property (
        @(posedge clk) disable iff (!arstN)
        wrEn |-> !$isunknown(wrAddr)
    ) else $error("regFile write with unknown address");

endmodule

`default_nettype wire

//--- design/forwardingUnit.sv
`default_nettype none

`include "forwardPipe_config.svh"

module forwardingUnit
    import forwardPipePkg::*;
(
    // Operand requests from the decode register
    input  logic    readA,
    input  logic    readB,
    input  regAddrT srcA,
    input  regAddrT srcB,
    input  dataT    regDataA,
    input  dataT    regDataB,

    // Slot 0 is the instruction in execute
    input  logic    fwd0Valid,
    input  regAddrT fwd0Addr,
    input  dataT    fwd0Data,

    // Slot 1 is the instruction in writeback
    input  logic    fwd1Valid,
    input  regAddrT fwd1Addr,
    input  dataT    fwd1Data,

    output dataT    opA,
    output dataT    opB
);

    logic fwd0ToA;
    logic fwd0ToB;
    logic fwd1ToA;
    logic fwd1ToB;

    // Priority select, newer slot 0 beats slot 1 beats the register file
    function automatic dataT selectOperand(
        input logic take0,
        input logic take1,
        input dataT slot0,
        input dataT slot1,
        input dataT regData
    );
        if (take0) begin
            return slot0;
        end else if (take1) begin
            return slot1;
        end
        return regData;
    endfunction

    // Match enables, one per slot per operand
    assign fwd0ToA = fwd0Valid && readA && (fwd0Addr == srcA);
    assign fwd0ToB = fwd0Valid && readB && (fwd0Addr == srcB);
    assign fwd1ToA = fwd1Valid && readA && (fwd1Addr == srcA);
    assign fwd1ToB = fwd1Valid && readB && (fwd1Addr == srcB);

    assign opA = selectOperand(fwd0ToA, fwd1ToA, fwd0Data, fwd1Data, regDataA);
    assign opB = selectOperand(fwd0ToB, fwd1ToB, fwd0Data, fwd1Data, regDataB);

    // Forwarded data from the execute stage must be defined when it is picked
    always_comb begin
        if (fwd0ToA || fwd0ToB) begin
            fwd0Known: assert (!$isunknown(fwd0Data))
                else $error("slot 0 selected with unknown data");
        end
        if (fwd1ToA || fwd1ToB) begin
            fwd1Known: assert (!$isunknown(fwd1Data))
                else $error("slot 1 selected with unknown data");
        end
    end

endmodule

`default_nettype wire

//--- design/issueStage.sv
`default_nettype none

`include "forwardPipe_config.svh"

module issueStage
    import forwardPipePkg::*;
(
    input  logic    clk,
    input  logic    arstN,
    input  logic    clkEn,

    // Incoming instruction
    input  logic    instValid,
    input  aluOpT   op,
    input  regAddrT dst,
    input  regAddrT srcA,
    input  regAddrT srcB,
    input  logic    useImm,
    input  dataT    imm,

    // Register file reads
    output regAddrT rdAddrA,
    output regAddrT rdAddrB,
    input  dataT    rdDataA,
    input  dataT    rdDataB,

    // Forward sources from the execute stage
    input  logic    fwd0Valid,
    input  regAddrT fwd0Addr,
    input  dataT    fwd0Data,
    input  logic    fwd1Valid,
    input  regAddrT fwd1Addr,
    input  dataT    fwd1Data,

    // Execute register
    output logic    exValid,
    output aluOpT   exOp,
    output regAddrT exDst,
    output dataT    exOpA,
    output dataT    exOpB
);

    // Decode register
    logic    decValid;
    aluOpT   decOp;
    regAddrT decDst;
    regAddrT decSrcA;
    regAddrT decSrcB;
    logic    decUseImm;
    dataT    decImm;

    dataT    resolvedA;
    dataT    resolvedB;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decValid <= 1'b0;
        end else if (clkEn) begin
            decValid <= instValid;
        end
    end

    always_ff @(posedge clk) begin
        if (clkEn) begin
            decOp     <= op;
            decDst    <= dst;
            decSrcA   <= srcA;
            decSrcB   <= srcB;
            decUseImm <= useImm;
            decImm    <= imm;
        end
    end

    assign rdAddrA = decSrcA;
    assign rdAddrB = decSrcB;

    // Operand B is not requested when the immediate replaces it
    forwardingUnit i_forwardingUnit (
        .readA     (decValid),
        .readB     (decValid && !decUseImm),
        .srcA      (decSrcA),
        .srcB      (decSrcB),
        .regDataA  (rdDataA),
        .regDataB  (rdDataB),
        .fwd0Valid (fwd0Valid),
        .fwd0Addr  (fwd0Addr),
        .fwd0Data  (fwd0Data),
        .fwd1Valid (fwd1Valid),
        .fwd1Addr  (fwd1Addr),
        .fwd1Data  (fwd1Data),
        .opA       (resolvedA),
        .opB       (resolvedB)
    );

    // A bubble in decode becomes a bubble in execute
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exValid <= 1'b0;
        end else if (clkEn) begin
            exValid <= decValid;
        end
    end

    always_ff @(posedge clk) begin
        if (clkEn) begin
            exOp  <= decOp;
            exDst <= decDst;
            exOpA <= resolvedA;
            exOpB <= decUseImm ? decImm : resolvedB;
        end
    end

endmodule

`default_nettype wire

//--- design/executeStage.sv
`default_nettype none

`include "forwardPipe_config.svh"

module executeStage
    import forwardPipePkg::*;
(
    input  logic    clk,
    input  logic    arstN,
    input  logic    clkEn,

    // Execute register contents from the issue stage
    input  logic    exValid,
    input  aluOpT   exOp,
    input  regAddrT exDst,
    input  dataT    exOpA,
    input  dataT    exOpB,

    // Slot 0, combinational result of the instruction in execute
    output logic    fwd0Valid,
    output regAddrT fwd0Addr,
    output dataT    fwd0Data,

    // Slot 1, the writeback register
    output logic    fwd1Valid,
    output regAddrT fwd1Addr,
    output dataT    fwd1Data
);

    localparam int ShiftBits = $clog2(`FP_DATA_WIDTH);

    dataT aluResult;

    // Add and sub wrap at the word width
    always_comb begin
        case (exOp)
            opAdd:   aluResult = exOpA + exOpB;
            opSub:   aluResult = exOpA - exOpB;
            opAnd:   aluResult = exOpA & exOpB;
            opOr:    aluResult = exOpA | exOpB;
            opXor:   aluResult = exOpA ^ exOpB;
            // Shift amount from the low bits of B
            opShl:   aluResult = exOpA << exOpB[ShiftBits-1:0];
            opPass:  aluResult = exOpB;
            default: aluResult = '0;
        endcase
    end

    assign fwd0Valid = exValid;
    assign fwd0Addr  = exDst;
    assign fwd0Data  = aluResult;

    // Writeback register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fwd1Valid <= 1'b0;
        end else if (clkEn) begin
            fwd1Valid <= exValid;
        end
    end

    always_ff @(posedge clk) begin
        if (clkEn) begin
            fwd1Addr <= exDst;
            fwd1Data <= aluResult;
        end
    end

    // Anything leaving for the register file must be defined
    wbDataKnown: assert property (
        @(posedge clk) disable iff (!arstN)
        fwd1Valid |-> !$isunknown(fwd1Data)
    ) else $error("writeback valid with unknown data");

endmodule

`default_nettype wire

//--- design/forwardPipe.sv
`default_nettype none

`include "forwardPipe_config.svh"

module forwardPipe
    import forwardPipePkg::*;
(
    input  logic    clk,
    input  logic    arstN,
    input  logic    clkEn,

    input  logic    instValid,
    input  aluOpT   op,
    input  regAddrT dst,
    input  regAddrT srcA,
    input  regAddrT srcB,
    input  logic    useImm,
    input  dataT    imm,

    output logic    wbValid,
    output regAddrT wbAddr,
    output dataT    wbData
);

    regAddrT rdAddrA;
    regAddrT rdAddrB;
    dataT    rdDataA;
    dataT    rdDataB;

    logic    exValid;
    aluOpT   exOp;
    regAddrT exDst;
    dataT    exOpA;
    dataT    exOpB;

    logic    fwd0Valid;
    regAddrT fwd0Addr;
    dataT    fwd0Data;
    logic    fwd1Valid;
    regAddrT fwd1Addr;
    dataT    fwd1Data;

    issueStage i_issueStage (
        .clk       (clk),
        .arstN     (arstN),
        .clkEn     (clkEn),
        .instValid (instValid),
        .op        (op),
        .dst       (dst),
        .srcA      (srcA),
        .srcB      (srcB),
        .useImm    (useImm),
        .imm       (imm),
        .rdAddrA   (rdAddrA),
        .rdAddrB   (rdAddrB),
        .rdDataA   (rdDataA),
        .rdDataB   (rdDataB),
        .fwd0Valid (fwd0Valid),
        .fwd0Addr  (fwd0Addr),
        .fwd0Data  (fwd0Data),
        .fwd1Valid (fwd1Valid),
        .fwd1Addr  (fwd1Addr),
        .fwd1Data  (fwd1Data),
        .exValid   (exValid),
        .exOp      (exOp),
        .exDst     (exDst),
        .exOpA     (exOpA),
        .exOpB     (exOpB)
    );

    // Stalled cycles must not write, so the write strobe follows clkEn
    regFile i_regFile (
        .clk     (clk),
        .arstN   (arstN),
        .wrEn    (fwd1Valid && clkEn),
        .wrAddr  (fwd1Addr),
        .wrData  (fwd1Data),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    executeStage i_executeStage (
        .clk       (clk),
        .arstN     (arstN),
        .clkEn     (clkEn),
        .exValid   (exValid),
        .exOp      (exOp),
        .exDst     (exDst),
        .exOpA     (exOpA),
        .exOpB     (exOpB),
        .fwd0Valid (fwd0Valid),
        .fwd0Addr  (fwd0Addr),
        .fwd0Data  (fwd0Data),
        .fwd1Valid (fwd1Valid),
        .fwd1Addr  (fwd1Addr),
        .fwd1Data  (fwd1Data)
    );

    // Writeback register is visible outside
    assign wbValid = fwd1Valid;
    assign wbAddr  = fwd1Addr;
    assign wbData  = fwd1Data;

endmodule

`default_nettype wire

//--- verif/forwardPipeTb.sv
`default_nettype none

module forwardPipeTb
    import forwardPipePkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    ResetCycles = 10;
    localparam int    SlackCycles = 20;
    localparam string TracePath   = "verif/forwardPipe_trace.txt";

    // One trace line, stimulus first and then the expected writeback
    typedef struct packed {
        logic [7:0] testId;
        logic       clkEn;
        logic       instValid;
        logic [2:0] op;
        regAddrT    dst;
        regAddrT    srcA;
        regAddrT    srcB;
        logic       useImm;
        dataT       imm;
        logic       expValid;
        regAddrT    expAddr;
        dataT       expData;
    } stepT;

    logic    clk;
    logic    arstN;
    logic    clkEn;
    logic    instValid;
    aluOpT   op;
    regAddrT dst;
    regAddrT srcA;
    regAddrT srcB;
    logic    useImm;
    dataT    imm;
    logic    wbValid;
    regAddrT wbAddr;
    dataT    wbData;

    stepT trace [$];
    int   errors;
    int   checks;
    int   cycleCount;
    int   cycleLimit;

    forwardPipe i_forwardPipe (
        .clk       (clk),
        .arstN     (arstN),
        .clkEn     (clkEn),
        .instValid (instValid),
        .op        (op),
        .dst       (dst),
        .srcA      (srcA),
        .srcB      (srcB),
        .useImm    (useImm),
        .imm       (imm),
        .wbValid   (wbValid),
        .wbAddr    (wbAddr),
        .wbData    (wbData)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic loadTrace();
        int         fd;
        int         items;
        int         lineNo;
        string      textLine;
        logic [7:0] testId;
        logic       en;
        logic       valid;
        logic [2:0] opCode;
        regAddrT    dstReg;
        regAddrT    srcAReg;
        regAddrT    srcBReg;
        logic       immSel;
        dataT       immVal;
        logic       expV;
        regAddrT    expA;
        dataT       expD;
        stepT       step;
        lineNo = 0;
        fd = $fopen(TracePath, "r");
        if (fd == 0) begin
            $display("cannot open the trace file %s", TracePath);
            errors++;
        end else begin
            while ($fgets(textLine, fd) > 0) begin
                lineNo++;
                // Comment and blank lines hold no step
                if (textLine.len() > 1 && textLine.substr(0, 0) != "#") begin
                    items = $sscanf(textLine, "%h %h %h %h %h %h %h %h %h %h %h %h",
                        testId, en, valid, opCode, dstReg, srcAReg, srcBReg,
                        immSel, immVal, expV, expA, expD);
                    if (items != 12) begin
                        $display("trace line %0d does not hold twelve fields", lineNo);
                        errors++;
                    end else begin
                        step.testId    = testId;
                        step.clkEn     = en;
                        step.instValid = valid;
                        step.op        = opCode;
                        step.dst       = dstReg;
                        step.srcA      = srcAReg;
                        step.srcB      = srcBReg;
                        step.useImm    = immSel;
                        step.imm       = immVal;
                        step.expValid  = expV;
                        step.expAddr   = expA;
                        step.expData   = expD;
                        trace.push_back(step);
                    end
                end
            end
            $fclose(fd);
        end
        if (trace.size() == 0) begin
            $display("the trace holds no steps, so nothing was tested");
            errors++;
        end
    endtask

    task automatic applyInputs(input stepT step);
        clkEn     = step.clkEn;
        instValid = step.instValid;
        op        = aluOpT'(step.op);
        dst       = step.dst;
        srcA      = step.srcA;
        srcB      = step.srcB;
        useImm    = step.useImm;
        imm       = step.imm;
    endtask

    // Address and data only mean something while wbValid is high
    task automatic checkOutputs(input stepT step, input int stepNo);
        checks++;
        assert (wbValid === step.expValid) else begin
            errors++;
            $display("error test %0d step %0d wbValid expected %0b actual %0b",
                step.testId, stepNo, step.expValid, wbValid);
        end
        if (step.expValid) begin
            assert (wbAddr === step.expAddr) else begin
                errors++;
                $display("error test %0d step %0d wbAddr expected %h actual %h",
                    step.testId, stepNo, step.expAddr, wbAddr);
            end
            assert (wbData === step.expData) else begin
                errors++;
                $display("error test %0d step %0d wbData expected %h actual %h",
                    step.testId, stepNo, step.expData, wbData);
            end
        end
    endtask

    task automatic applyReset();
        arstN = 1'b0;
        repeat (ResetCycles) begin
            @(posedge clk);
            #5;
            checks++;
            assert (wbValid === 1'b0) else begin
                errors++;
                $display("error test 1 reset wbValid expected 0 actual %0b", wbValid);
            end
        end
        #5;
        arstN = 1'b1;
    endtask

    // Each line is checked against the last edge, then its stimulus goes out
    task automatic runTrace();
        for (int k = 0; k < trace.size(); k++) begin
            @(posedge clk);
            #5;
            checkOutputs(trace[k], k);
            #5;
            applyInputs(trace[k]);
        end
    endtask

    initial begin
        arstN     = 1'b0;
        clkEn     = 1'b1;
        instValid = 1'b0;
        op        = opAdd;
        dst       = '0;
        srcA      = '0;
        srcB      = '0;
        useImm    = 1'b0;
        imm       = '0;
        errors    = 0;
        checks    = 0;
        loadTrace();
        cycleLimit = trace.size() + ResetCycles + SlackCycles;
        applyReset();
        runTrace();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Cycle budget for the whole run
    initial begin
        cycleCount = 0;
        wait (cycleLimit > 0);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout, the run did not end within %0d cycles", cycleLimit);
        $display("%0d checks, %0d errors", checks, errors);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+design
design/forwardPipePkg.sv
design/regFile.sv
design/forwardingUnit.sv
design/issueStage.sv
design/executeStage.sv
design/forwardPipe.sv
verif/forwardPipeTb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and judges the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=forwardPipeSim

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f src.f --top-module forwardPipeTb -o "$BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
    echo "Result: pass"
    exit 0
fi
echo "Result: fail"
exit 1

//--- verif/forwardPipe_trace.txt
# test clkEn instValid op dst srcA srcB useImm imm expValid expAddr expData (all hex)
# op 0 add 1 sub 2 and 3 or 4 xor 5 shl 6 pass, expected columns checked before the line drives
1 1 1 0 1 2 3 0 0000 0 0 0000
1 1 1 6 4 0 0 1 1234 0 0 0000
1 1 1 6 5 0 0 1 00f3 0 0 0000
1 1 0 0 0 0 0 0 0000 1 1 0000
2 1 0 0 0 0 0 0 0000 1 4 1234
2 1 0 0 0 0 0 0 0000 1 5 00f3
2 1 1 0 6 4 5 0 0000 0 0 0000
2 1 1 1 7 4 5 0 0000 0 0 0000
2 1 1 2 8 4 5 0 0000 0 0 0000
2 1 1 3 9 4 5 0 0000 1 6 1327
2 1 1 4 a 4 5 0 0000 1 7 1141
2 1 1 5 b 4 5 0 0000 1 8 0030
2 1 1 6 1 0 0 1 0005 1 9 12f7
2 1 1 0 2 1 1 0 0000 1 a 12c7
2 1 1 0 3 2 2 0 0000 1 b 91a0
3 1 1 6 c 0 0 1 0100 1 1 0005
3 1 1 6 d 0 0 1 0011 1 2 000a
3 1 1 0 e c d 0 0000 1 3 0014
4 1 1 1 f c d 0 0000 1 c 0100
4 1 1 6 7 0 0 1 0aaa 1 d 0011
4 1 1 6 7 0 7 1 0555 1 e 0111
4 1 1 0 8 7 7 0 0000 1 f 00ef
5 1 1 6 9 0 0 1 0003 1 7 0aaa
5 1 1 5 a 9 9 1 0002 1 7 0555
5 0 1 6 f 0 0 1 ffff 1 8 0aaa
6 0 1 6 f 0 0 1 ffff 1 8 0aaa
6 0 1 6 f 0 0 1 ffff 1 8 0aaa
6 1 1 0 b a 9 0 0000 1 8 0aaa
6 1 0 0 0 0 0 0 0000 1 9 0003
6 1 0 0 0 0 0 0 0000 1 a 000c
6 1 0 0 0 0 0 0 0000 1 b 000f
6 1 0 0 0 0 0 0 0000 0 0 0000
6 1 0 0 0 0 0 0 0000 0 0 0000
